// File: chien/chien_eval.sv
module chien_eval #(
    parameter int N_POS = chien_pkg::CODE_N
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_load,
    input  gf_pkg::gf_elem_t   i_sigma0,
    input  gf_pkg::gf_elem_t   i_sigma1,
    input  gf_pkg::gf_elem_t   i_sigma2,
    input  chien_pkg::deg_t    i_degree,
    input  logic               i_correct,
    output logic [N_POS-1:0]   o_roots,
    output logic               o_load,
    output chien_pkg::deg_t    o_degree,
    output logic               o_correct
);

    gf_pkg::gf_elem_t sigma0_q;
    gf_pkg::gf_elem_t sigma1_q;
    gf_pkg::gf_elem_t sigma2_q;
    chien_pkg::deg_t  degree_q;
    logic             correct_q;
    logic             load_q;
    logic [N_POS-1:0] is_root;

    // ----------------------------------------------------------------------
    // stage 1: input register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            sigma0_q  <= i_sigma0;
            sigma1_q  <= i_sigma1;
            sigma2_q  <= i_sigma2;
            degree_q  <= i_degree;
            correct_q <= i_correct;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= i_load;
        end
    end

    // one pe per codeword position, all evaluated in parallel
    for (genvar j = 0; j < N_POS; j++) begin : g_pe
        chien_pe #(
            .POSITION(j)
        ) u_pe (
            .i_sigma0  (sigma0_q),
            .i_sigma1  (sigma1_q),
            .i_sigma2  (sigma2_q),
            .o_is_root (is_root[j])
        );
    end

    // ----------------------------------------------------------------------
    // stage 2: root vector register
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        o_roots   <= is_root;
        o_degree  <= degree_q;
        o_correct <= correct_q;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_load <= 1'b0;
        end else begin
            o_load <= load_q;
        end
    end

endmodule

// File: chien/chien_pe.sv
module chien_pe #(
    parameter int POSITION = 0
) (
    input  gf_pkg::gf_elem_t i_sigma0,
    input  gf_pkg::gf_elem_t i_sigma1,
    input  gf_pkg::gf_elem_t i_sigma2,
    output logic             o_is_root
);

    // alpha^-j and alpha^-2j, folded into the field order
    localparam int EXP1 = (gf_pkg::GF_ORDER - (POSITION % gf_pkg::GF_ORDER))
                          % gf_pkg::GF_ORDER;
    localparam int EXP2 = (gf_pkg::GF_ORDER - ((2 * POSITION) % gf_pkg::GF_ORDER))
                          % gf_pkg::GF_ORDER;

    localparam gf_pkg::gf_elem_t ALPHA_J  = gf_pkg::gf_pow_alpha(EXP1);
    localparam gf_pkg::gf_elem_t ALPHA_2J = gf_pkg::gf_pow_alpha(EXP2);

    gf_pkg::gf_elem_t term1;
    gf_pkg::gf_elem_t term2;
    gf_pkg::gf_elem_t sum;

    assign term1 = gf_pkg::gf_mul(i_sigma1, ALPHA_J);
    assign term2 = gf_pkg::gf_mul(i_sigma2, ALPHA_2J);

    // sigma(alpha^-j)
    assign sum = i_sigma0 ^ term1 ^ term2;

    assign o_is_root = (sum == '0);

endmodule

// File: common/chien_pkg.sv
package chien_pkg;

    // (63,51) bch, t = 2
    localparam int CODE_N = 63;
    localparam int MAX_ERR = 2;

    // codeword position 0..62
    typedef logic [$clog2(CODE_N)-1:0] pos_t;

    // root count, top value means more than MAX_ERR roots
    typedef logic [$clog2(MAX_ERR + 2)-1:0] cnt_t;

    // claimed locator degree from the key equation solver
    typedef logic [$clog2(MAX_ERR + 2)-1:0] deg_t;

    // saturated count value
    localparam cnt_t CNT_SAT = cnt_t'(MAX_ERR + 1);

endpackage

// File: common/gf_pkg.sv
package gf_pkg;

    localparam int GF_M = 6;
    // x^6 + x + 1
    localparam logic [GF_M:0] GF_POLY = 7'b1000011;
    localparam int GF_ORDER = 63;

    typedef logic [GF_M-1:0] gf_elem_t;

    // ----------------------------------------------------------------------
    // polynomial basis arithmetic
    // ----------------------------------------------------------------------

    // msb-first shift and add, reduced every step
    function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
        logic [GF_M:0] p;
        p = '0;
        for (int i = GF_M - 1; i >= 0; i--) begin
            p = p << 1;
            if (p[GF_M]) begin
                p = p ^ GF_POLY;
            end
            if (b[i]) begin
                p = p ^ {1'b0, a};
            end
        end
        return p[GF_M-1:0];
    endfunction

    // alpha^e, exponent taken mod field order
    function automatic gf_elem_t gf_pow_alpha(int unsigned e);
        gf_elem_t r;
        r = gf_elem_t'(1);
        for (int unsigned k = 0; k < e % GF_ORDER; k++) begin
            r = gf_mul(r, gf_elem_t'(2));
        end
        return r;
    endfunction

endpackage

// File: hw/chien_search_top.sv
module chien_search_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_load,
    input  gf_pkg::gf_elem_t  i_sigma0,
    input  gf_pkg::gf_elem_t  i_sigma1,
    input  gf_pkg::gf_elem_t  i_sigma2,
    input  chien_pkg::deg_t   i_degree,
    input  logic              i_correct,
    output chien_pkg::pos_t   o_err_loc0,
    output chien_pkg::pos_t   o_err_loc1,
    output chien_pkg::cnt_t   o_num_err,
    output logic              o_correct,
    output logic              o_err_valid
);

    localparam int N_POS = chien_pkg::CODE_N;

    logic [N_POS-1:0] r_roots;
    logic             load_d2;
    chien_pkg::deg_t  degree_d2;
    logic             correct_d2;

    // stages 1 and 2
    chien_eval #(
        .N_POS(N_POS)
    ) u_eval (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_load    (i_load),
        .i_sigma0  (i_sigma0),
        .i_sigma1  (i_sigma1),
        .i_sigma2  (i_sigma2),
        .i_degree  (i_degree),
        .i_correct (i_correct),
        .o_roots   (r_roots),
        .o_load    (load_d2),
        .o_degree  (degree_d2),
        .o_correct (correct_d2)
    );

    // stage 3
    root_locator #(
        .N_POS(N_POS)
    ) u_locator (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_roots     (r_roots),
        .i_load      (load_d2),
        .i_degree    (degree_d2),
        .i_correct   (correct_d2),
        .o_err_loc0  (o_err_loc0),
        .o_err_loc1  (o_err_loc1),
        .o_num_err   (o_num_err),
        .o_correct   (o_correct),
        .o_err_valid (o_err_valid)
    );

endmodule

// File: hw/root_locator.sv
module root_locator #(
    parameter int N_POS = chien_pkg::CODE_N
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [N_POS-1:0]   i_roots,
    input  logic               i_load,
    input  chien_pkg::deg_t    i_degree,
    input  logic               i_correct,
    output chien_pkg::pos_t    o_err_loc0,
    output chien_pkg::pos_t    o_err_loc1,
    output chien_pkg::cnt_t    o_num_err,
    output logic               o_correct,
    output logic               o_err_valid
);

    chien_pkg::pos_t loc0_c;
    chien_pkg::pos_t loc1_c;
    chien_pkg::cnt_t cnt_c;
    logic            correct_c;

    // ----------------------------------------------------------------------
    // priority scan from position 0 upward
    // ----------------------------------------------------------------------
    always_comb begin
        loc0_c = '0;
        loc1_c = '0;
        cnt_c  = '0;
        for (int j = 0; j < N_POS; j++) begin
            if (i_roots[j]) begin
                if (cnt_c == chien_pkg::cnt_t'(0)) begin
                    loc0_c = chien_pkg::pos_t'(j);
                end else if (cnt_c == chien_pkg::cnt_t'(1)) begin
                    loc1_c = chien_pkg::pos_t'(j);
                end
                // stop counting once past t
                if (cnt_c != chien_pkg::CNT_SAT) begin
                    cnt_c = cnt_c + chien_pkg::cnt_t'(1);
                end
            end
        end
    end

    // root count must agree with the claimed degree
    assign correct_c = i_correct && (cnt_c == i_degree);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_err_loc0  <= '0;
            o_err_loc1  <= '0;
            o_num_err   <= '0;
            o_correct   <= 1'b0;
            o_err_valid <= 1'b0;
        end else begin
            o_err_valid <= i_load;
            if (i_load) begin
                o_err_loc0 <= loc0_c;
                o_err_loc1 <= loc1_c;
                o_num_err  <= cnt_c;
                o_correct  <= correct_c;
            end
        end
    end

endmodule

// File: project.f
common/gf_pkg.sv
common/chien_pkg.sv
chien/chien_pe.sv
chien/chien_eval.sv
hw/root_locator.sv
hw/chien_search_top.sv
sim/chien_search_props.sv
sim/tb_chien_search.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the chien search testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_chien_search \
    -f project.f \
    -Mdir "$OBJ" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation clean, see $LOG"
exit 0

// File: sim/chien_search_props.sv
module chien_search_props (
    input logic            i_clk,
    input logic            i_rst_n,
    input logic            i_load,
    input logic            o_err_valid,
    input chien_pkg::pos_t o_err_loc0,
    input chien_pkg::pos_t o_err_loc1,
    input chien_pkg::cnt_t o_num_err
);

    // no result pulses while reset is held
    a_quiet_in_reset: assert property (
        @(posedge i_clk) !i_rst_n |=> !o_err_valid
    ) else $error("o_err_valid high during reset");

    // fixed three cycle latency, one pulse per load
    a_valid_latency: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_err_valid == $past(i_load, 3)
    ) else $error("o_err_valid does not follow i_load by three cycles");

    // unused second slot reads zero, two filled slots ascend
    a_slot_order: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_err_valid |-> ((o_num_err >= chien_pkg::cnt_t'(2)) ? (o_err_loc0 < o_err_loc1)
                                                           : (o_err_loc1 == '0))
    ) else $error("o_err_loc1 inconsistent with o_num_err");

endmodule

bind chien_search_top chien_search_props u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_load      (i_load),
    .o_err_valid (o_err_valid),
    .o_err_loc0  (o_err_loc0),
    .o_err_loc1  (o_err_loc1),
    .o_num_err   (o_num_err)
);

// File: sim/tb_chien_search.sv
module tb_chien_search;

    localparam int RST_CYC  = 8;
    localparam int IDLE_CYC = 10;
    localparam int N_TWO    = 30;
    localparam int N_ONE    = 20;
    localparam int N_RAND   = 60;
    localparam int N_B2B    = 20;
    localparam int N_FLAG   = 10;
    localparam int MAX_GAP  = 3;
    localparam int N_LOADS  = N_TWO + N_ONE + N_RAND + 1 + N_B2B + N_FLAG;
    // each test ends with one idle cycle and a pipeline drain
    localparam int TIMEOUT_CYC = N_LOADS * (1 + MAX_GAP) + 6 * 8 + IDLE_CYC + RST_CYC + 100;

    logic             i_clk = 1'b0;
    logic             i_rst_n;
    logic             i_load;
    gf_pkg::gf_elem_t i_sigma0;
    gf_pkg::gf_elem_t i_sigma1;
    gf_pkg::gf_elem_t i_sigma2;
    chien_pkg::deg_t  i_degree;
    logic             i_correct;
    chien_pkg::pos_t  o_err_loc0;
    chien_pkg::pos_t  o_err_loc1;
    chien_pkg::cnt_t  o_num_err;
    logic             o_correct;
    logic             o_err_valid;

    chien_search_top UUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load      (i_load),
        .i_sigma0    (i_sigma0),
        .i_sigma1    (i_sigma1),
        .i_sigma2    (i_sigma2),
        .i_degree    (i_degree),
        .i_correct   (i_correct),
        .o_err_loc0  (o_err_loc0),
        .o_err_loc1  (o_err_loc1),
        .o_num_err   (o_num_err),
        .o_correct   (o_correct),
        .o_err_valid (o_err_valid)
    );

    always #10 i_clk = ~i_clk;

    // ----------------------------------------------------------------------
    // bookkeeping, random source and field tables
    // ----------------------------------------------------------------------
    int    cyc = 0;
    int    total_errors = 0;
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    results_seen = 0;
    string cur_test = "reset";

    logic [31:0]      lcg_state;
    gf_pkg::gf_elem_t exp_tab [0:62];
    int               log_tab [0:63];

    // expected results, oldest first
    chien_pkg::pos_t exp_loc0_q[$];
    chien_pkg::pos_t exp_loc1_q[$];
    chien_pkg::cnt_t exp_cnt_q[$];
    logic            exp_cor_q[$];
    int              exp_cyc_q[$];

    chien_pkg::pos_t last_loc0 = '0;
    chien_pkg::pos_t last_loc1 = '0;
    chien_pkg::cnt_t last_cnt = '0;
    logic            last_cor = 1'b0;
    int              due_cyc;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic gf_pkg::gf_elem_t rand_elem();
        logic [31:0] r;
        r = next_rand();
        return r[21:16];
    endfunction

    function automatic int rand_pos();
        logic [31:0] r;
        r = next_rand();
        return r[31:16] % chien_pkg::CODE_N;
    endfunction

    // antilog and log tables by repeated multiply by alpha
    task automatic build_tables();
        logic [gf_pkg::GF_M:0] v;
        v = 7'd1;
        for (int i = 0; i < gf_pkg::GF_ORDER; i++) begin
            exp_tab[i] = v[gf_pkg::GF_M-1:0];
            log_tab[v[gf_pkg::GF_M-1:0]] = i;
            v = v << 1;
            if (v[gf_pkg::GF_M]) begin
                v = v ^ gf_pkg::GF_POLY;
            end
        end
    endtask

    function automatic gf_pkg::gf_elem_t field_mul(gf_pkg::gf_elem_t a, gf_pkg::gf_elem_t b);
        if (a == '0 || b == '0) begin
            return '0;
        end
        return exp_tab[(log_tab[a] + log_tab[b]) % gf_pkg::GF_ORDER];
    endfunction

    // ----------------------------------------------------------------------
    // reference model and compare tasks
    // ----------------------------------------------------------------------
    task automatic push_expected(input gf_pkg::gf_elem_t s0, input gf_pkg::gf_elem_t s1,
                                 input gf_pkg::gf_elem_t s2, input chien_pkg::deg_t deg,
                                 input logic cor);
        int               n;
        int               loc_a;
        int               loc_b;
        gf_pkg::gf_elem_t x;
        chien_pkg::cnt_t  cnt;
        n = 0;
        loc_a = 0;
        loc_b = 0;
        for (int j = 0; j < chien_pkg::CODE_N; j++) begin
            // x = alpha^-j
            x = exp_tab[(gf_pkg::GF_ORDER - j) % gf_pkg::GF_ORDER];
            if ((s0 ^ field_mul(s1, x) ^ field_mul(s2, field_mul(x, x))) == '0) begin
                if (n == 0) begin
                    loc_a = j;
                end else if (n == 1) begin
                    loc_b = j;
                end
                n++;
            end
        end
        cnt = (n > 3) ? chien_pkg::cnt_t'(3) : chien_pkg::cnt_t'(n);
        exp_loc0_q.push_back(chien_pkg::pos_t'(loc_a));
        exp_loc1_q.push_back(chien_pkg::pos_t'(loc_b));
        exp_cnt_q.push_back(cnt);
        exp_cor_q.push_back(cor && (cnt == deg));
        exp_cyc_q.push_back(cyc + 3);
    endtask

    task automatic note_error();
        total_errors++;
        test_errors++;
    endtask

    task automatic check_pos(input string what, input chien_pkg::pos_t exp,
                             input chien_pkg::pos_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_cnt(input string what, input chien_pkg::cnt_t exp,
                             input chien_pkg::cnt_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
            note_error();
        end
    endtask

    // results are compared mid-cycle, away from the driving edge
    always @(negedge i_clk) begin
        if (!i_rst_n && o_err_valid === 1'b1) begin
            $display("error in %s: o_err_valid high while reset is held", cur_test);
            note_error();
        end
        if (i_rst_n && o_err_valid) begin
            if (exp_cyc_q.size() == 0) begin
                $display("error in %s: o_err_valid pulsed with no load outstanding",
                         cur_test);
                note_error();
            end else begin
                results_seen++;
                due_cyc = exp_cyc_q.pop_front();
                if (due_cyc != cyc) begin
                    $display("FAIL %s latency: expected cycle %0d, actual cycle %0d",
                             cur_test, due_cyc, cyc);
                    note_error();
                end
                check_pos("o_err_loc0", exp_loc0_q.pop_front(), o_err_loc0);
                check_pos("o_err_loc1", exp_loc1_q.pop_front(), o_err_loc1);
                check_cnt("o_num_err", exp_cnt_q.pop_front(), o_num_err);
                check_bit("o_correct", exp_cor_q.pop_front(), o_correct);
            end
            last_loc0 = o_err_loc0;
            last_loc1 = o_err_loc1;
            last_cnt  = o_num_err;
            last_cor  = o_correct;
        end else if (i_rst_n) begin
            check_pos("held o_err_loc0", last_loc0, o_err_loc0);
            check_pos("held o_err_loc1", last_loc1, o_err_loc1);
            check_cnt("held o_num_err", last_cnt, o_num_err);
            check_bit("held o_correct", last_cor, o_correct);
        end
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, %0d results still pending",
                     cyc, exp_cyc_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic send(input gf_pkg::gf_elem_t s0, input gf_pkg::gf_elem_t s1,
                        input gf_pkg::gf_elem_t s2, input chien_pkg::deg_t deg,
                        input logic cor);
        @(posedge i_clk);
        #2;
        i_sigma0  = s0;
        i_sigma1  = s1;
        i_sigma2  = s2;
        i_degree  = deg;
        i_correct = cor;
        i_load    = 1'b1;
        push_expected(s0, s1, s2, deg, cor);
    endtask

    // idle cycles carry junk on the data inputs
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            #2;
            i_load   = 1'b0;
            i_sigma0 = rand_elem();
            i_sigma1 = rand_elem();
            i_sigma2 = rand_elem();
        end
    endtask

    task automatic rand_gap();
        logic [31:0] r;
        r = next_rand();
        idle(int'(r[17:16]));
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        idle(1);
        while (exp_cyc_q.size() != 0) begin
            @(negedge i_clk);
            #1;
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %-14s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", cur_test, test_errors);
        end
    endtask

    // (1 + alpha^i x)(1 + alpha^k x) with i < k
    task automatic send_two_root(input chien_pkg::deg_t deg, input logic cor);
        int i;
        int k;
        int t;
        i = rand_pos();
        k = rand_pos();
        while (k == i) begin
            k = rand_pos();
        end
        if (i > k) begin
            t = i;
            i = k;
            k = t;
        end
        send(6'd1, exp_tab[i] ^ exp_tab[k], exp_tab[(i + k) % gf_pkg::GF_ORDER], deg, cor);
    endtask

    task automatic send_random();
        logic [31:0] r;
        r = next_rand();
        send(rand_elem(), rand_elem(), rand_elem(), chien_pkg::deg_t'(r[9:8]), r[12]);
    endtask

    initial begin
        lcg_state = 32'h70bb8926;
        build_tables();
        i_rst_n   = 1'b0;
        i_load    = 1'b0;
        i_sigma0  = '0;
        i_sigma1  = '0;
        i_sigma2  = '0;
        i_degree  = '0;
        i_correct = 1'b0;
        repeat (RST_CYC) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;

        start_test("idle");
        repeat (IDLE_CYC) begin
            @(negedge i_clk);
            check_bit("o_err_valid", 1'b0, o_err_valid);
            check_bit("o_correct", 1'b0, o_correct);
            check_pos("o_err_loc0", '0, o_err_loc0);
            check_pos("o_err_loc1", '0, o_err_loc1);
            check_cnt("o_num_err", '0, o_num_err);
        end
        finish_test();

        start_test("two_roots");
        for (int n = 0; n < N_TWO; n++) begin
            send_two_root((n % 4 == 3) ? chien_pkg::deg_t'(1) : chien_pkg::deg_t'(2), 1'b1);
            rand_gap();
        end
        finish_test();

        start_test("one_root");
        for (int n = 0; n < N_ONE; n++) begin
            send(6'd1, exp_tab[rand_pos()], 6'd0, 2'd1, 1'b1);
            rand_gap();
        end
        finish_test();

        start_test("random");
        // zero polynomial, every position is a root
        send(6'd0, 6'd0, 6'd0, 2'd3, 1'b1);
        for (int n = 0; n < N_RAND; n++) begin
            send_random();
            rand_gap();
        end
        finish_test();

        start_test("back_to_back");
        for (int n = 0; n < N_B2B; n++) begin
            if (n % 2 == 0) begin
                send_two_root(2'd2, 1'b1);
            end else begin
                send_random();
            end
        end
        finish_test();

        start_test("flag_low");
        for (int n = 0; n < N_FLAG; n++) begin
            send_two_root(2'd2, 1'b0);
            rand_gap();
        end
        finish_test();

        $display("tests passed %0d, tests failed %0d, results checked %0d, errors %0d",
                 tests_passed, tests_failed, results_seen, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
